//--- files.f
logic/prefetch_pkg.sv
logic/tmr_pkg.sv
logic/fetch_requester.sv
logic/instr_fifo.sv
logic/tmr_voter.sv
logic/breakage_monitor.sv
logic/prefetch_buffer_tmr.sv
tests/prefetch_buffer_tmr_asserts.sv
tests/prefetch_buffer_tmr_tb.sv

//--- logic/breakage_monitor.sv
////////////////////////////////////////
// Breakage monitor
// Leaky error counter for one lane, sets a sticky broken flag
////////////////////////////////////////
`timescale 1ns/1ns

module breakage_monitor #(
        parameter int unsigned COUNT_BITS = 4,
        parameter int unsigned INCREMENT  = 3,
        parameter int unsigned DECREMENT  = 1,
        parameter int unsigned THRESHOLD  = 9
) (
        input  logic clk,
        input  logic rst_n_i,
        input  logic err_detected_i,
        input  logic set_broken_i,
        output logic is_broken_o
);
        localparam logic [COUNT_BITS:0] COUNT_MAX = {1'b0, {COUNT_BITS{1'b1}}};

        logic [COUNT_BITS-1:0] count_q, count_d;
        logic [COUNT_BITS:0]   count_up;
        logic                  broken_q;

        // Spare top bit shows the overflow before saturating
        assign count_up = {1'b0, count_q} + (COUNT_BITS+1)'(INCREMENT);

        always_comb begin
                if (err_detected_i) begin
                        count_d = (count_up > COUNT_MAX) ? COUNT_MAX[COUNT_BITS-1:0]
                                                         : count_up[COUNT_BITS-1:0];
                end else if (count_q > COUNT_BITS'(DECREMENT)) begin
                        count_d = count_q - COUNT_BITS'(DECREMENT);
                end else begin
                        count_d = '0;
                end
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        count_q  <= '0;
                        broken_q <= 1'b0;
                end else begin
                        count_q <= count_d;
                        // Once broken the lane stays out until reset
                        if (set_broken_i || ({1'b0, count_q} >= (COUNT_BITS+1)'(THRESHOLD)))
                                broken_q <= 1'b1;
                end
        end

        assign is_broken_o = broken_q;

endmodule

//--- logic/fetch_requester.sv
////////////////////////////////////////
// Fetch requester
// Walks the instruction stream with one memory transaction in
// flight and hands returned words to the FIFO
////////////////////////////////////////
`timescale 1ns/1ns

module fetch_requester (
        input  logic                 clk,
        input  logic                 rst_n_i,
        input  logic                 req_i,
        input  logic                 branch_i,
        input  prefetch_pkg::addr_t  branch_addr_i,
        input  logic                 fifo_full_i,
        input  logic                 instr_gnt_i,
        input  logic                 instr_rvalid_i,
        input  prefetch_pkg::instr_t instr_rdata_i,
        output logic                 instr_req_o,
        output prefetch_pkg::addr_t  instr_addr_o,
        output logic                 push_o,
        output prefetch_pkg::instr_t push_data_o,
        output logic                 busy_o
);
        import prefetch_pkg::*;

        fetch_state_e state_q, state_d;
        addr_t        addr_q, addr_d;

        // Idle raises the request as soon as the FIFO has room,
        // FETCH_REQ holds it until the grant
        assign instr_req_o  = (state_q == FETCH_REQ) ||
                              (state_q == FETCH_IDLE && req_i && !fifo_full_i);
        assign instr_addr_o = addr_q;
        assign busy_o       = (state_q == FETCH_WAIT) || (state_q == FETCH_DROP);

        // Words answering a request from before a branch never reach the FIFO
        assign push_o       = (state_q == FETCH_WAIT) && instr_rvalid_i && !branch_i;
        assign push_data_o  = instr_rdata_i;

        always_comb begin
                state_d = state_q;
                addr_d  = addr_q;
                case (state_q)
                        FETCH_IDLE, FETCH_REQ: begin
                                if (instr_req_o && instr_gnt_i) begin
                                        // Granted in the branch cycle, so the word is stale
                                        state_d = branch_i ? FETCH_DROP : FETCH_WAIT;
                                end else if (instr_req_o) begin
                                        state_d = FETCH_REQ;
                                end
                        end
                        FETCH_WAIT: begin
                                if (instr_rvalid_i) begin
                                        state_d = FETCH_IDLE;
                                        addr_d  = addr_q + WORD_BYTES;
                                end else if (branch_i) begin
                                        state_d = FETCH_DROP;
                                end
                        end
                        FETCH_DROP: begin
                                if (instr_rvalid_i)
                                        state_d = FETCH_IDLE;
                        end
                        default: state_d = FETCH_IDLE;
                endcase

                // Branch target overrides the sequential address
                if (branch_i)
                        addr_d = branch_addr_i;
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state_q <= FETCH_IDLE;
                        addr_q  <= RESET_ADDR;
                end else begin
                        state_q <= state_d;
                        addr_q  <= addr_d;
                end
        end

endmodule

//--- logic/instr_fifo.sv
////////////////////////////////////////
// Instruction FIFO
// Circular buffer of fetched words, drained by the core and
// emptied on a branch
////////////////////////////////////////
`timescale 1ns/1ns

module instr_fifo #(
        parameter int unsigned FIFO_DEPTH = 4
) (
        input  logic                 clk,
        input  logic                 rst_n_i,
        input  logic                 push_i,
        input  prefetch_pkg::instr_t push_data_i,
        input  logic                 flush_i,
        input  logic                 fetch_ready_i,
        output logic                 fetch_valid_o,
        output prefetch_pkg::instr_t fetch_rdata_o,
        output logic                 full_o
);
        import prefetch_pkg::*;

        localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
        localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

        instr_t           mem_q [FIFO_DEPTH];
        logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
        logic [CNT_W-1:0] count_q;
        logic             push, pop;

        // Pointer step with wrap for any depth
        function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
                if (ptr == PTR_W'(FIFO_DEPTH - 1))
                        return '0;
                return ptr + 1'b1;
        endfunction

        assign fetch_valid_o = (count_q != '0);
        assign fetch_rdata_o = mem_q[rd_ptr_q];
        assign full_o        = (count_q == CNT_W'(FIFO_DEPTH));

        // A push in the flush cycle is dropped
        assign push = push_i && !flush_i && !full_o;
        assign pop  = fetch_ready_i && fetch_valid_o;

        always_ff @(posedge clk) begin
                if (push)
                        mem_q[wr_ptr_q] <= push_data_i;
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        rd_ptr_q <= '0;
                        wr_ptr_q <= '0;
                        count_q  <= '0;
                end else if (flush_i) begin
                        rd_ptr_q <= '0;
                        wr_ptr_q <= '0;
                        count_q  <= '0;
                end else begin
                        if (push)
                                wr_ptr_q <= ptr_next(wr_ptr_q);
                        if (pop)
                                rd_ptr_q <= ptr_next(rd_ptr_q);
                        if (push && !pop)
                                count_q <= count_q + 1'b1;
                        else if (pop && !push)
                                count_q <= count_q - 1'b1;
                end
        end

endmodule

//--- logic/prefetch_buffer_tmr.sv
////////////////////////////////////////
// Triple redundant prefetch buffer
// Three fetch replicas merged by majority voters, with a
// breakage monitor retiring lanes that keep disagreeing
////////////////////////////////////////
`timescale 1ns/1ns

module prefetch_buffer_tmr #(
        parameter int unsigned FIFO_DEPTH = 4,
        parameter int unsigned COUNT_BITS = 4,
        parameter int unsigned INCREMENT  = 3,
        parameter int unsigned DECREMENT  = 1,
        parameter int unsigned THRESHOLD  = 9
) (
        input  logic                                          clk,
        input  logic                                          rst_n_i,
        input  logic [tmr_pkg::NUM_LANES-1:0]                 req_i,
        input  logic [tmr_pkg::NUM_LANES-1:0]                 branch_i,
        input  prefetch_pkg::addr_t [tmr_pkg::NUM_LANES-1:0]  branch_addr_i,
        input  logic [tmr_pkg::NUM_LANES-1:0]                 fetch_ready_i,
        input  logic [tmr_pkg::NUM_LANES-1:0]                 instr_gnt_i,
        input  prefetch_pkg::instr_t [tmr_pkg::NUM_LANES-1:0] instr_rdata_i,
        input  logic [tmr_pkg::NUM_LANES-1:0]                 instr_rvalid_i,
        input  tmr_pkg::lane_mask_t                           set_broken_i,
        output logic                                          fetch_valid_o,
        output prefetch_pkg::instr_t                          fetch_rdata_o,
        output logic                                          instr_req_o,
        output prefetch_pkg::addr_t                           instr_addr_o,
        output logic                                          busy_o,
        output tmr_pkg::lane_mask_t                           is_broken_o,
        output logic                                          err_detected_o,
        output logic                                          err_corrected_o
);
        import prefetch_pkg::*;
        import tmr_pkg::*;

        // Replica outputs before voting
        logic [NUM_LANES-1:0]   lane_valid, lane_req, lane_busy;
        instr_t [NUM_LANES-1:0] lane_rdata;
        addr_t [NUM_LANES-1:0]  lane_addr;

        // Mismatch masks, one per voter
        lane_mask_t valid_err, rdata_err, req_err, addr_err, busy_err;
        lane_mask_t lane_err;
        logic [4:0] voter_detected, voter_corrected;

        ////////////////////////////////////////
        // Replicas and their monitors
        ////////////////////////////////////////

        for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
                logic   push;
                instr_t push_data;
                logic   fifo_full;

                fetch_requester i_fetch_requester (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .req_i          (req_i[k]),
                        .branch_i       (branch_i[k]),
                        .branch_addr_i  (branch_addr_i[k]),
                        .fifo_full_i    (fifo_full),
                        .instr_gnt_i    (instr_gnt_i[k]),
                        .instr_rvalid_i (instr_rvalid_i[k]),
                        .instr_rdata_i  (instr_rdata_i[k]),
                        .instr_req_o    (lane_req[k]),
                        .instr_addr_o   (lane_addr[k]),
                        .push_o         (push),
                        .push_data_o    (push_data),
                        .busy_o         (lane_busy[k])
                );

                instr_fifo #(
                        .FIFO_DEPTH (FIFO_DEPTH)
                ) i_instr_fifo (
                        .clk           (clk),
                        .rst_n_i       (rst_n_i),
                        .push_i        (push),
                        .push_data_i   (push_data),
                        .flush_i       (branch_i[k]),
                        .fetch_ready_i (fetch_ready_i[k]),
                        .fetch_valid_o (lane_valid[k]),
                        .fetch_rdata_o (lane_rdata[k]),
                        .full_o        (fifo_full)
                );

                breakage_monitor #(
                        .COUNT_BITS (COUNT_BITS),
                        .INCREMENT  (INCREMENT),
                        .DECREMENT  (DECREMENT),
                        .THRESHOLD  (THRESHOLD)
                ) i_breakage_monitor (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .err_detected_i (lane_err[k]),
                        .set_broken_i   (set_broken_i[k]),
                        .is_broken_o    (is_broken_o[k])
                );
        end

        // A lane is at fault if any of its five outputs was outvoted
        assign lane_err = valid_err | rdata_err | req_err | addr_err | busy_err;

        ////////////////////////////////////////
        // Voters
        ////////////////////////////////////////

        tmr_voter #(.WIDTH(1)) i_vote_fetch_valid (
                .to_vote_i       (lane_valid),
                .broken_i        (is_broken_o),
                .voted_o         (fetch_valid_o),
                .block_err_o     (valid_err),
                .err_detected_o  (voter_detected[0]),
                .err_corrected_o (voter_corrected[0])
        );

        tmr_voter #(.WIDTH($bits(instr_t))) i_vote_fetch_rdata (
                .to_vote_i       (lane_rdata),
                .broken_i        (is_broken_o),
                .voted_o         (fetch_rdata_o),
                .block_err_o     (rdata_err),
                .err_detected_o  (voter_detected[1]),
                .err_corrected_o (voter_corrected[1])
        );

        tmr_voter #(.WIDTH(1)) i_vote_instr_req (
                .to_vote_i       (lane_req),
                .broken_i        (is_broken_o),
                .voted_o         (instr_req_o),
                .block_err_o     (req_err),
                .err_detected_o  (voter_detected[2]),
                .err_corrected_o (voter_corrected[2])
        );

        tmr_voter #(.WIDTH($bits(addr_t))) i_vote_instr_addr (
                .to_vote_i       (lane_addr),
                .broken_i        (is_broken_o),
                .voted_o         (instr_addr_o),
                .block_err_o     (addr_err),
                .err_detected_o  (voter_detected[3]),
                .err_corrected_o (voter_corrected[3])
        );

        tmr_voter #(.WIDTH(1)) i_vote_busy (
                .to_vote_i       (lane_busy),
                .broken_i        (is_broken_o),
                .voted_o         (busy_o),
                .block_err_o     (busy_err),
                .err_detected_o  (voter_detected[4]),
                .err_corrected_o (voter_corrected[4])
        );

        assign err_detected_o  = |voter_detected;
        assign err_corrected_o = |voter_corrected;

endmodule

//--- logic/prefetch_pkg.sv
////////////////////////////////////////
// Prefetch types
// Address and instruction word types, requester states and the
// address fetching starts from after reset
////////////////////////////////////////

package prefetch_pkg;

        // Byte address of one instruction word
        typedef logic [31:0] addr_t;

        // Raw instruction word as returned by memory
        typedef logic [31:0] instr_t;

        // Fetch requester states
        typedef enum logic [1:0] {
                FETCH_IDLE,
                FETCH_REQ,
                FETCH_WAIT,
                FETCH_DROP
        } fetch_state_e;

        localparam addr_t RESET_ADDR = 32'h0000_0000;
        localparam addr_t WORD_BYTES = 32'd4;

endpackage

//--- logic/tmr_pkg.sv
////////////////////////////////////////
// Redundancy types
// Lane count and per-lane mask for the triplicated logic
////////////////////////////////////////

package tmr_pkg;

        // Number of identical replicas
        localparam int unsigned NUM_LANES = 3;

        // One bit per replica
        typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

//--- logic/tmr_voter.sv
////////////////////////////////////////
// TMR voter
// Majority vote over the healthy lanes with a per-lane
// mismatch mask for the breakage monitors
////////////////////////////////////////
`timescale 1ns/1ns

module tmr_voter #(
        parameter int unsigned WIDTH = 1
) (
        input  logic [tmr_pkg::NUM_LANES-1:0][WIDTH-1:0] to_vote_i,
        input  tmr_pkg::lane_mask_t                      broken_i,
        output logic [WIDTH-1:0]                         voted_o,
        output tmr_pkg::lane_mask_t                      block_err_o,
        output logic                                     err_detected_o,
        output logic                                     err_corrected_o
);
        import tmr_pkg::*;

        lane_mask_t       healthy;
        logic [WIDTH-1:0] majority;
        int unsigned      lo_lane, hi_lane;

        assign healthy  = ~broken_i;
        assign majority = (to_vote_i[0] & to_vote_i[1]) |
                          (to_vote_i[0] & to_vote_i[2]) |
                          (to_vote_i[1] & to_vote_i[2]);

        // Lowest and highest healthy lane, lane 0 if none is left
        always_comb begin
                lo_lane = 0;
                hi_lane = 0;
                for (int k = NUM_LANES - 1; k >= 0; k--) begin
                        if (healthy[k])
                                lo_lane = k;
                end
                for (int k = 0; k < NUM_LANES; k++) begin
                        if (healthy[k])
                                hi_lane = k;
                end
        end

        always_comb begin
                voted_o         = to_vote_i[lo_lane];
                block_err_o     = '0;
                err_detected_o  = 1'b0;
                err_corrected_o = 1'b0;
                case ($countones(healthy))
                        NUM_LANES: begin
                                voted_o = majority;
                                for (int k = 0; k < NUM_LANES; k++) begin
                                        block_err_o[k] = (to_vote_i[k] != majority);
                                end
                                err_detected_o  = |block_err_o;
                                err_corrected_o = ($countones(block_err_o) == 1);
                        end
                        2: begin
                                // Two lanes cannot outvote each other, only detect
                                err_detected_o = (to_vote_i[lo_lane] != to_vote_i[hi_lane]);
                        end
                        default: ;
                endcase
        end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the prefetch buffer TMR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module prefetch_buffer_tmr_tb \
        -f files.f -o sim_prefetch_buffer_tmr

out=$(./obj_dir/sim_prefetch_buffer_tmr)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"

//--- tests/fetch_golden.hex
// One 32-bit instruction word per line, word addresses 0 to 31
// Memory contents, also the expected fetch stream in address order
00000297
02028293
00000313
00a00393
00530e33
0003a023
00438393
fff30313
fe031ae3
00100513
00b50533
00c585b3
40b50633
00d676b3
00e6e733
00f747b3
01079813
4107d893
0108a903
0128a223
00291993
01398a33
01499ab3
015a0b33
016abbb3
017b4c33
018bdcb3
019c6d33
01acfdb3
01bd8e33
0000006f
00008067

//--- tests/prefetch_buffer_tmr_asserts.sv
////////////////////////////////////////
// Prefetch buffer TMR assertions
// Bus and redundancy properties bound to the top level
////////////////////////////////////////
`timescale 1ns/1ns

module prefetch_buffer_tmr_asserts (
        input logic                          clk,
        input logic                          rst_n_i,
        input logic [tmr_pkg::NUM_LANES-1:0] branch_i,
        input logic [tmr_pkg::NUM_LANES-1:0] instr_gnt_i,
        input logic                          instr_req_o,
        input prefetch_pkg::addr_t           instr_addr_o,
        input logic                          fetch_valid_o,
        input tmr_pkg::lane_mask_t           is_broken_o,
        input logic                          err_detected_o,
        input logic                          err_corrected_o
);

        // Retired lanes stay retired until reset
        broken_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
                (is_broken_o & $past(is_broken_o)) == $past(is_broken_o))
                else $error("is_broken_o dropped a retired lane");

        corrected_implies_detected: assert property (@(posedge clk) disable iff (!rst_n_i)
                err_corrected_o |-> err_detected_o)
                else $error("err_corrected_o without err_detected_o");

        // A pending request keeps its address until granted
        addr_stable_until_gnt: assert property (@(posedge clk) disable iff (!rst_n_i)
                instr_req_o && !instr_gnt_i[0] && !branch_i[0] |=> $stable(instr_addr_o))
                else $error("instr_addr_o changed before the grant");

        valid_low_after_branch: assert property (@(posedge clk) disable iff (!rst_n_i)
                branch_i[0] |=> !fetch_valid_o)
                else $error("fetch_valid_o high in the cycle after a branch");

endmodule

bind prefetch_buffer_tmr prefetch_buffer_tmr_asserts i_prefetch_buffer_tmr_asserts (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .branch_i        (branch_i),
        .instr_gnt_i     (instr_gnt_i),
        .instr_req_o     (instr_req_o),
        .instr_addr_o    (instr_addr_o),
        .fetch_valid_o   (fetch_valid_o),
        .is_broken_o     (is_broken_o),
        .err_detected_o  (err_detected_o),
        .err_corrected_o (err_corrected_o)
);

//--- tests/prefetch_buffer_tmr_tb.sv
////////////////////////////////////////
// Prefetch buffer TMR testbench
// Memory model, core side stimulus and stream checks against
// the golden memory image
////////////////////////////////////////
`timescale 1ns/1ns

module prefetch_buffer_tmr_tb;
        import prefetch_pkg::*;
        import tmr_pkg::*;

        localparam int unsigned FIFO_DEPTH = 4;
        localparam int unsigned MEM_WORDS  = 32;

        logic                   clk;
        logic                   rst_n_i;
        logic [NUM_LANES-1:0]   req_i, branch_i, fetch_ready_i;
        logic [NUM_LANES-1:0]   instr_gnt_i, instr_rvalid_i;
        addr_t [NUM_LANES-1:0]  branch_addr_i;
        instr_t [NUM_LANES-1:0] instr_rdata_i;
        lane_mask_t             set_broken_i;
        logic                   fetch_valid_o, instr_req_o, busy_o;
        instr_t                 fetch_rdata_o;
        addr_t                  instr_addr_o;
        lane_mask_t             is_broken_o;
        logic                   err_detected_o, err_corrected_o;

        instr_t      golden [MEM_WORDS];
        logic [31:0] rng;
        int          errors, timeouts, accepted, occ, ready_mode;
        int unsigned exp_idx;
        logic        pend, pend_drop, corrupt, do_branch, branch_last;
        logic        corrupt_lane1;
        addr_t       pend_addr, branch_target;
        lane_mask_t  broken_seen;

        prefetch_buffer_tmr #(.FIFO_DEPTH(FIFO_DEPTH)) i_prefetch_buffer_tmr (.*);

        always #4 clk = ~clk;

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] s;
                s = x ^ (x << 13);
                s = s ^ (s >> 17);
                s = s ^ (s << 5);
                return s;
        endfunction

        task automatic report_mismatch(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
                $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
                errors++;
        endtask

        task automatic report_error(input string what);
                $display("ERROR t=%0t %s", $time, what);
                errors++;
        endtask

        ////////////////////////////////////////
        // One cycle seen from the falling edge
        ////////////////////////////////////////

        task automatic clock_cycle();
                logic ready;
                logic resp;
                logic pop;
                @(negedge clk);
                // Outputs here settled after the last rising edge
                if (branch_last && fetch_valid_o)
                        report_error("fetch_valid_o high in the cycle after a branch");
                if (fetch_valid_o !== (occ != 0))
                        report_mismatch("fetch_valid_o", fetch_valid_o, occ != 0);
                if (busy_o !== pend)
                        report_mismatch("busy_o", busy_o, pend);
                if (occ == FIFO_DEPTH && instr_req_o)
                        report_error("instr_req_o high while the FIFO is full");
                if ((broken_seen & ~is_broken_o) != '0)
                        report_mismatch("is_broken_o", is_broken_o, broken_seen);
                broken_seen |= is_broken_o;
                if (corrupt && fetch_valid_o && !is_broken_o[2] &&
                    !(err_detected_o && err_corrected_o))
                        report_error("corrupted lane 2 word at the FIFO head not corrected");
                if ((!corrupt || is_broken_o[2]) && err_detected_o)
                        report_mismatch("err_detected_o", err_detected_o, 1'b0);

                branch_i       = do_branch ? '1 : '0;
                branch_addr_i  = {NUM_LANES{branch_target}};
                instr_gnt_i    = '0;
                instr_rvalid_i = '0;
                resp           = 1'b0;
                // Memory answers one cycle after the grant
                if (pend) begin
                        resp           = !pend_drop && !do_branch;
                        instr_rvalid_i = '1;
                        instr_rdata_i  = {NUM_LANES{golden[pend_addr[6:2]]}};
                        if (corrupt) begin
                                rng              = xorshift32(rng);
                                instr_rdata_i[2] = instr_rdata_i[2] ^ rng;
                        end
                        // Retired lane 1 returns garbage so only lane 0 can match
                        if (corrupt_lane1)
                                instr_rdata_i[1] = ~instr_rdata_i[1];
                        pend = 1'b0;
                end else if (rst_n_i && instr_req_o) begin
                        instr_gnt_i = '1;
                        pend        = 1'b1;
                        pend_addr   = instr_addr_o;
                        pend_drop   = do_branch;
                end

                case (ready_mode)
                        0: ready = 1'b1;
                        1: begin
                                rng   = xorshift32(rng);
                                ready = rng[3];
                        end
                        default: ready = 1'b0;
                endcase
                fetch_ready_i = {NUM_LANES{ready}};
                pop = fetch_valid_o && ready;
                if (pop) begin
                        if (fetch_rdata_o !== golden[exp_idx])
                                report_mismatch("fetch_rdata_o", fetch_rdata_o, golden[exp_idx]);
                        exp_idx = (exp_idx + 1) % MEM_WORDS;
                        accepted++;
                end
                if (do_branch) begin
                        occ     = 0;
                        exp_idx = branch_target[6:2];
                end else begin
                        occ = occ + int'(resp) - int'(pop);
                end
                branch_last = do_branch;
                do_branch   = 1'b0;
        endtask

        task automatic run_words(input int count, input int limit);
                int target;
                int waited;
                target = accepted + count;
                waited = 0;
                while (accepted < target && waited < limit) begin
                        clock_cycle();
                        waited++;
                end
                if (accepted < target) begin
                        $display("ERROR t=%0t timed out waiting for %0d fetched words", $time, count);
                        timeouts++;
                end
        endtask

        task automatic wait_broken(input int lane, input int limit);
                int waited;
                waited = 0;
                while (!is_broken_o[lane] && waited < limit) begin
                        clock_cycle();
                        waited++;
                end
                if (!is_broken_o[lane]) begin
                        $display("ERROR t=%0t lane %0d was never retired", $time, lane);
                        timeouts++;
                end
        endtask

        ////////////////////////////////////////
        // Test sequence
        ////////////////////////////////////////

        initial begin
                clk = 1'b0;
                rst_n_i = 1'b0;
                req_i = '0;
                branch_i = '0;
                branch_addr_i = '0;
                fetch_ready_i = '0;
                instr_gnt_i = '0;
                instr_rvalid_i = '0;
                instr_rdata_i = '0;
                set_broken_i = '0;
                rng = 32'h7966;
                {errors, timeouts, accepted, occ, ready_mode} = '0;
                exp_idx = 0;
                {pend, pend_drop, corrupt, do_branch, branch_last} = '0;
                corrupt_lane1 = 1'b0;
                pend_addr = '0;
                branch_target = '0;
                broken_seen = '0;
                $readmemh("tests/fetch_golden.hex", golden);
                if ($isunknown(golden[MEM_WORDS-1]))
                        report_error("golden memory image did not load");

                repeat (5) @(posedge clk);
                @(negedge clk);
                rst_n_i = 1'b1;
                if (instr_req_o !== 1'b0)
                        report_mismatch("instr_req_o", instr_req_o, 1'b0);
                if (fetch_valid_o !== 1'b0)
                        report_mismatch("fetch_valid_o", fetch_valid_o, 1'b0);
                if (busy_o !== 1'b0)
                        report_mismatch("busy_o", busy_o, 1'b0);
                if (err_detected_o !== 1'b0)
                        report_mismatch("err_detected_o", err_detected_o, 1'b0);
                if (err_corrected_o !== 1'b0)
                        report_mismatch("err_corrected_o", err_corrected_o, 1'b0);
                if (is_broken_o !== '0)
                        report_mismatch("is_broken_o", is_broken_o, '0);

                // Full speed stream from the reset address
                req_i = '1;
                run_words(MEM_WORDS, 200);

                // Random back-pressure, then a stall that fills the FIFO
                ready_mode = 1;
                run_words(24, 400);
                ready_mode = 2;
                repeat (12) clock_cycle();
                if (occ != FIFO_DEPTH)
                        report_error("FIFO did not fill while the core stalled");
                ready_mode = 1;
                run_words(16, 300);

                // Branches, the second one wraps past the end of memory
                branch_target = 32'h0000_0050;
                do_branch = 1'b1;
                run_words(20, 300);
                branch_target = 32'h0000_0074;
                do_branch = 1'b1;
                run_words(12, 300);

                // Lane 2 data corrupted from a clean FIFO on
                branch_target = 32'h0000_0010;
                do_branch = 1'b1;
                clock_cycle();
                corrupt = 1'b1;
                wait_broken(2, 200);
                run_words(16, 300);

                // Software retires lane 1, lane 0 carries on alone
                set_broken_i = 3'b010;
                clock_cycle();
                set_broken_i = '0;
                if (!is_broken_o[1])
                        report_mismatch("is_broken_o", is_broken_o, 3'b110);
                corrupt_lane1 = 1'b1;
                run_words(24, 400);
                if (is_broken_o !== 3'b110)
                        report_mismatch("is_broken_o", is_broken_o, 3'b110);

                $display("Done: %0d errors, %0d timeouts, %0d words accepted",
                         errors, timeouts, accepted);
                if (errors == 0 && timeouts == 0)
                        $display("SIMULATION PASSED");
                else
                        $display("SIMULATION FAILED");
                $finish;
        end

endmodule
